/* load_store_unit.f */
logic/lsu_pkg.sv
logic/lsu_issue_ctrl.sv
logic/load_unit.sv
logic/store_buffer.sv
logic/wb_master_arbiter.sv
logic/load_store_unit.sv
sim/wb_mem_model.sv
sim/tb_load_store_unit.sv

/* run_sim.sh */
#!/bin/sh
# build and run the load/store unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f load_store_unit.f \
    --top-module tb_load_store_unit -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulator returned status $status"
    exit 1
fi

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
    echo "no result line in sim.log"
    exit 1
fi
exit 0

/* sim/tb_load_store_unit.sv */
`timescale 1ns/10ps

module tb_load_store_unit;

    // room for six short tests
    localparam int MAX_CYCLES = 4000;

    logic                clk_i;
    logic                rst_ni;
    logic                flush_i;
    logic                lsu_valid_i;
    lsu_pkg::lsu_req_t   lsu_req_i;
    logic                lsu_ready_o;
    logic                commit_i;
    logic                commit_ready_o;
    logic                no_st_pending_o;
    lsu_pkg::wb_result_t load_wb_o;
    lsu_pkg::wb_result_t store_wb_o;
    lsu_pkg::wb_req_t    wb_o;
    lsu_pkg::wb_rsp_t    wb_i;

    logic [31:0] ref_mem [0:255];
    logic [31:0] exp_val [8];
    logic        exp_ex [8];
    logic [3:0]  exp_cause [8];
    int          iss_cnt [8];
    int          done_cnt [8];
    logic [31:0] sq_adr [$];
    logic [31:0] sq_dat [$];
    logic [31:0] sq_mask [$];
    logic [2:0]  next_tid;
    logic        fixed_lat;
    logic        misal_window;
    int          errors;
    int          tests;
    int          cycles;

    load_store_unit #(.STORE_BUF_DEPTH(4)) u_dut (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .flush_i         (flush_i),
        .lsu_valid_i     (lsu_valid_i),
        .lsu_req_i       (lsu_req_i),
        .lsu_ready_o     (lsu_ready_o),
        .commit_i        (commit_i),
        .commit_ready_o  (commit_ready_o),
        .no_st_pending_o (no_st_pending_o),
        .load_wb_o       (load_wb_o),
        .store_wb_o      (store_wb_o),
        .wb_o            (wb_o),
        .wb_i            (wb_i)
    );

    wb_mem_model u_mem (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .req_i  (wb_o),
        .rsp_o  (wb_i)
    );

    always #5 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // count writebacks per tag on the falling edge
    always @(negedge clk_i) begin
        if (load_wb_o.valid) begin
            done_cnt[load_wb_o.trans_id] <= done_cnt[load_wb_o.trans_id] + 1;
        end
        if (store_wb_o.valid) begin
            done_cnt[store_wb_o.trans_id] <= done_cnt[store_wb_o.trans_id] + 1;
        end
    end

    // --------------------------------------------------
    // checks
    // --------------------------------------------------
    ld_result: assert property (@(negedge clk_i) disable iff (!rst_ni)
        load_wb_o.valid |-> load_wb_o.result == exp_val[load_wb_o.trans_id])
        else begin
            $display("[ERROR] %0t load_wb_o.result got %h expected %h", $time,
                     load_wb_o.result, exp_val[load_wb_o.trans_id]);
            errors++;
        end

    ld_ex: assert property (@(negedge clk_i) disable iff (!rst_ni)
        load_wb_o.valid |-> load_wb_o.ex_valid == exp_ex[load_wb_o.trans_id])
        else begin
            $display("[ERROR] %0t load_wb_o.ex_valid got %b expected %b", $time,
                     load_wb_o.ex_valid, exp_ex[load_wb_o.trans_id]);
            errors++;
        end

    ld_cause: assert property (@(negedge clk_i) disable iff (!rst_ni)
        load_wb_o.valid && load_wb_o.ex_valid |->
            4'(load_wb_o.cause) == exp_cause[load_wb_o.trans_id])
        else begin
            $display("[ERROR] %0t load_wb_o.cause got %0d expected %0d", $time,
                     load_wb_o.cause, exp_cause[load_wb_o.trans_id]);
            errors++;
        end

    st_ex: assert property (@(negedge clk_i) disable iff (!rst_ni)
        store_wb_o.valid |-> store_wb_o.ex_valid == exp_ex[store_wb_o.trans_id])
        else begin
            $display("[ERROR] %0t store_wb_o.ex_valid got %b expected %b", $time,
                     store_wb_o.ex_valid, exp_ex[store_wb_o.trans_id]);
            errors++;
        end

    st_result: assert property (@(negedge clk_i) disable iff (!rst_ni)
        store_wb_o.valid && store_wb_o.ex_valid |->
            store_wb_o.result == exp_val[store_wb_o.trans_id])
        else begin
            $display("[ERROR] %0t store_wb_o.result got %h expected %h", $time,
                     store_wb_o.result, exp_val[store_wb_o.trans_id]);
            errors++;
        end

    st_cause: assert property (@(negedge clk_i) disable iff (!rst_ni)
        store_wb_o.valid && store_wb_o.ex_valid |->
            4'(store_wb_o.cause) == exp_cause[store_wb_o.trans_id])
        else begin
            $display("[ERROR] %0t store_wb_o.cause got %0d expected %0d", $time,
                     store_wb_o.cause, exp_cause[store_wb_o.trans_id]);
            errors++;
        end

    // stores and misaligned loads answer two edges after acceptance
    fixed_latency: assert property (@(negedge clk_i) disable iff (!rst_ni || flush_i)
        lsu_valid_i && lsu_ready_o && fixed_lat |-> ##2
            ((store_wb_o.valid && store_wb_o.trans_id == $past(lsu_req_i.trans_id, 2))
            || (load_wb_o.valid && load_wb_o.trans_id == $past(lsu_req_i.trans_id, 2))))
        else begin
            $display("%0t writeback did not arrive two edges after acceptance", $time);
            errors++;
        end

    once_only: assert property (@(negedge clk_i) disable iff (!rst_ni)
        (!load_wb_o.valid || done_cnt[load_wb_o.trans_id] < iss_cnt[load_wb_o.trans_id])
        && (!store_wb_o.valid
            || done_cnt[store_wb_o.trans_id] < iss_cnt[store_wb_o.trans_id]))
        else begin
            $display("%0t a tag was written back more often than it was issued", $time);
            errors++;
        end

    bus_stable: assert property (@(negedge clk_i) disable iff (!rst_ni)
        wb_o.cyc && !wb_i.ack && !wb_i.err |=> wb_o.cyc && wb_o.stb
            && $stable(wb_o.adr) && $stable(wb_o.we) && $stable(wb_o.sel) && $stable(wb_o.dat))
        else begin
            $display("%0t the Wishbone request changed before ack or err", $time);
            errors++;
        end

    no_bus_misal: assert property (@(negedge clk_i) disable iff (!rst_ni)
        misal_window |-> !wb_o.cyc)
        else begin
            $display("%0t a misaligned access started a bus cycle", $time);
            errors++;
        end

    // --------------------------------------------------
    // reference model and stimulus
    // --------------------------------------------------
    function automatic logic [1:0] size_of(input lsu_pkg::lsu_op_e op);
        if (op == lsu_pkg::LB || op == lsu_pkg::LBU || op == lsu_pkg::SB) return 2'd0;
        if (op == lsu_pkg::LH || op == lsu_pkg::LHU || op == lsu_pkg::SH) return 2'd1;
        return 2'd2;
    endfunction

    function automatic logic all_done();
        for (int i = 0; i < 8; i++) begin
            if (iss_cnt[i] != done_cnt[i]) return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic issue(input lsu_pkg::lsu_op_e op, input logic [31:0] base,
                         input logic [31:0] ofs, input logic [31:0] data);
        logic [31:0] addr;
        logic [31:0] sh;
        logic [1:0]  sz;
        logic [2:0]  tid;
        logic        mis;
        logic        ld;
        addr = base + ofs;
        sz   = size_of(op);
        ld   = op inside {lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::LW};
        mis  = (sz == 2'd1 && addr[0]) || (sz == 2'd2 && addr[1:0] != 2'b00);
        tid  = next_tid;
        next_tid = next_tid + 3'd1;
        @(posedge clk_i);
        while (iss_cnt[tid] != done_cnt[tid]) @(posedge clk_i);
        #1;
        exp_ex[tid]    = mis || (ld && addr >= 32'h8000_0000);
        exp_cause[tid] = ld ? (mis ? 4'd4 : 4'd5) : 4'd6;
        exp_val[tid]   = exp_ex[tid] ? addr : 32'd0;
        if (ld && !exp_ex[tid]) begin
            sh = ref_mem[addr[9:2]] >> {addr[1:0], 3'b000};
            case (op)
                lsu_pkg::LB:  exp_val[tid] = {{24{sh[7]}}, sh[7:0]};
                lsu_pkg::LBU: exp_val[tid] = {24'd0, sh[7:0]};
                lsu_pkg::LH:  exp_val[tid] = {{16{sh[15]}}, sh[15:0]};
                lsu_pkg::LHU: exp_val[tid] = {16'd0, sh[15:0]};
                default:      exp_val[tid] = sh;
            endcase
        end
        if (!ld && !mis) begin
            sq_adr.push_back({addr[31:2], 2'b00});
            sq_dat.push_back(data << {addr[1:0], 3'b000});
            sq_mask.push_back((sz == 2'd0 ? 32'hFF : sz == 2'd1 ? 32'hFFFF : 32'hFFFF_FFFF)
                              << {addr[1:0], 3'b000});
        end
        lsu_req_i.op        = op;
        lsu_req_i.operand_a = base;
        lsu_req_i.imm       = ofs;
        lsu_req_i.operand_b = data;
        lsu_req_i.trans_id  = tid;
        lsu_valid_i         = 1'b1;
        fixed_lat           = !ld || mis;
        iss_cnt[tid]        = iss_cnt[tid] + 1;
        while (!lsu_ready_o) begin
            @(posedge clk_i);
            #1;
        end
        @(posedge clk_i);
        #1;
        lsu_valid_i = 1'b0;
        fixed_lat   = 1'b0;
    endtask

    task automatic wait_idle();
        while (!all_done() || !no_st_pending_o) @(posedge clk_i);
        @(posedge clk_i);
        #1;
    endtask

    // oldest speculative store becomes architectural
    task automatic commit_one();
        logic [31:0] a;
        while (!commit_ready_o) begin
            @(posedge clk_i);
            #1;
        end
        commit_i = 1'b1;
        a = sq_adr.pop_front();
        ref_mem[a[9:2]] = (ref_mem[a[9:2]] & ~sq_mask[0]) | (sq_dat[0] & sq_mask[0]);
        void'(sq_dat.pop_front());
        void'(sq_mask.pop_front());
        @(posedge clk_i);
        #1;
        commit_i = 1'b0;
    endtask

    task automatic end_test(input string name);
        wait_idle();
        tests++;
        $display("test %0d %s finished, errors so far %0d", tests, name, errors);
    endtask

    initial begin
        clk_i        = 1'b0;
        rst_ni       = 1'b0;
        flush_i      = 1'b0;
        commit_i     = 1'b0;
        lsu_valid_i  = 1'b0;
        lsu_req_i    = '0;
        fixed_lat    = 1'b0;
        misal_window = 1'b0;
        next_tid     = 3'd0;
        errors       = 0;
        tests        = 0;
        cycles       = 0;
        for (int i = 0; i < 8; i++) begin
            iss_cnt[i]  = 0;
            done_cnt[i] = 0;
        end
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = ({22'd0, i[7:0], 2'b00} * 32'h9E37_79B1) ^ 32'hC3A5_5A3C;
        end
        repeat (16) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        issue(lsu_pkg::SW, 32'h40, 32'h0, 32'h89AB_CDEF);
        issue(lsu_pkg::SB, 32'h40, 32'h5, 32'h0000_00F1);
        wait_idle();
        commit_one();
        commit_one();
        wait_idle();
        issue(lsu_pkg::LB, 32'h40, 32'h3, 32'h0);
        issue(lsu_pkg::LBU, 32'h40, 32'h1, 32'h0);
        issue(lsu_pkg::LH, 32'h40, 32'h2, 32'h0);
        issue(lsu_pkg::LHU, 32'h40, 32'h0, 32'h0);
        issue(lsu_pkg::LW, 32'h44, 32'h0, 32'h0);
        end_test("write then read");

        issue(lsu_pkg::SH, 32'h80, 32'h2, 32'h0000_7E5A);
        end_test("store writeback");
        commit_one();
        wait_idle();

        misal_window = 1'b1;
        issue(lsu_pkg::LH, 32'h100, 32'h1, 32'h0);
        issue(lsu_pkg::LW, 32'h100, 32'h2, 32'h0);
        issue(lsu_pkg::SH, 32'h100, 32'h3, 32'h1234_5678);
        issue(lsu_pkg::SW, 32'h100, 32'h5, 32'hDEAD_BEEF);
        wait_idle();
        misal_window = 1'b0;
        issue(lsu_pkg::LW, 32'h100, 32'h0, 32'h0);
        issue(lsu_pkg::LW, 32'h104, 32'h0, 32'h0);
        end_test("misaligned access");

        issue(lsu_pkg::SW, 32'hC0, 32'h0, 32'h5555_AAAA);
        wait_idle();
        flush_i = 1'b1;
        sq_adr.delete();
        sq_dat.delete();
        sq_mask.delete();
        @(posedge clk_i);
        #1;
        flush_i = 1'b0;
        // the commit after the flush must pick the new store
        issue(lsu_pkg::SW, 32'hC4, 32'h0, 32'h0F0F_3C3C);
        wait_idle();
        commit_one();
        assert (!no_st_pending_o)
            else begin
                $display("[ERROR] %0t no_st_pending_o got %b expected 0", $time,
                         no_st_pending_o);
                errors++;
            end
        issue(lsu_pkg::LW, 32'hC0, 32'h0, 32'h0);
        issue(lsu_pkg::LW, 32'hC4, 32'h0, 32'h0);
        end_test("flush");

        for (int i = 0; i < 4; i++) begin
            issue(lsu_pkg::SW, 32'h200, 32'(i * 4), 32'hA000_0000 + 32'(i));
        end
        while (!all_done()) @(posedge clk_i);
        #1;
        for (int i = 0; i < 4; i++) begin
            commit_one();
        end
        for (int i = 0; i < 4; i++) begin
            issue(lsu_pkg::LW, 32'h200, 32'(i * 4), 32'h0);
        end
        end_test("ordering under back-pressure");

        issue(lsu_pkg::LW, 32'h8000_0000, 32'h10, 32'h0);
        end_test("access fault");

        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* sim/wb_mem_model.sv */
`timescale 1ns/10ps

module wb_mem_model #(
    parameter logic [31:0] FAULT_BASE = 32'h8000_0000
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  lsu_pkg::wb_req_t req_i,
    output lsu_pkg::wb_rsp_t rsp_o
);

    logic [31:0] mem [0:255];
    logic [31:0] dat_q;
    logic [31:0] lane_mask;
    logic [1:0]  wait_q;
    logic        active_q;
    logic        ack_q;
    logic        err_q;
    integer      seed;

    // each word starts from a pattern of its full address
    initial begin
        seed = 32'hde86d84a;
        for (int i = 0; i < 256; i++) begin
            mem[i] = ({22'd0, i[7:0], 2'b00} * 32'h9E37_79B1) ^ 32'hC3A5_5A3C;
        end
    end

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            lane_mask[b*8 +: 8] = {8{req_i.sel[b]}};
        end
    end

    // --------------------------------------------------
    // slave with 1 to 4 random wait cycles
    // --------------------------------------------------
    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ack_q    <= 1'b0;
            err_q    <= 1'b0;
            active_q <= 1'b0;
            wait_q   <= 2'd0;
            dat_q    <= 32'd0;
        end else begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
            if (req_i.cyc && req_i.stb && !ack_q && !err_q) begin
                if (!active_q) begin
                    active_q <= 1'b1;
                    wait_q   <= 2'($random(seed));
                end else if (wait_q != 2'd0) begin
                    wait_q <= wait_q - 2'd1;
                end else begin
                    active_q <= 1'b0;
                    if (req_i.adr >= FAULT_BASE) begin
                        err_q <= 1'b1;
                    end else begin
                        ack_q <= 1'b1;
                        dat_q <= mem[req_i.adr[9:2]];
                        if (req_i.we) begin
                            mem[req_i.adr[9:2]] <= (mem[req_i.adr[9:2]] & ~lane_mask)
                                                 | (req_i.dat & lane_mask);
                        end
                    end
                end
            end
        end
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.err = err_q;
    assign rsp_o.dat = dat_q;

endmodule

/* logic/load_store_unit.sv */
`timescale 1ns/10ps

module load_store_unit #(
    parameter int unsigned STORE_BUF_DEPTH = 4
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                flush_i,
    input  logic                lsu_valid_i,
    input  lsu_pkg::lsu_req_t   lsu_req_i,
    output logic                lsu_ready_o,
    input  logic                commit_i,
    output logic                commit_ready_o,
    output logic                no_st_pending_o,
    output lsu_pkg::wb_result_t load_wb_o,
    output lsu_pkg::wb_result_t store_wb_o,
    output lsu_pkg::wb_req_t    wb_o,
    input  lsu_pkg::wb_rsp_t    wb_i
);

    lsu_pkg::lsu_ctrl_t ctrl;
    logic               pop_ld;
    logic               pop_st;
    logic               hazard;
    lsu_pkg::data_t     ld_word_adr;
    lsu_pkg::wb_req_t   ld_wb_req;
    lsu_pkg::wb_req_t   st_wb_req;
    lsu_pkg::wb_rsp_t   ld_wb_rsp;
    lsu_pkg::wb_rsp_t   st_wb_rsp;

    lsu_issue_ctrl u_issue_ctrl (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .lsu_valid_i (lsu_valid_i),
        .lsu_req_i   (lsu_req_i),
        .pop_ld_i    (pop_ld),
        .pop_st_i    (pop_st),
        .lsu_ready_o (lsu_ready_o),
        .ctrl_o      (ctrl)
    );

    load_unit u_load_unit (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_i       (flush_i),
        .ctrl_i        (ctrl),
        .hazard_i      (hazard),
        .pop_ld_o      (pop_ld),
        .ld_word_adr_o (ld_word_adr),
        .wb_req_o      (ld_wb_req),
        .wb_rsp_i      (ld_wb_rsp),
        .load_wb_o     (load_wb_o)
    );

    store_buffer #(
        .STORE_BUF_DEPTH (STORE_BUF_DEPTH)
    ) u_store_buffer (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .flush_i         (flush_i),
        .commit_i        (commit_i),
        .ctrl_i          (ctrl),
        .ld_word_adr_i   (ld_word_adr),
        .hazard_o        (hazard),
        .pop_st_o        (pop_st),
        .commit_ready_o  (commit_ready_o),
        .no_st_pending_o (no_st_pending_o),
        .wb_req_o        (st_wb_req),
        .wb_rsp_i        (st_wb_rsp),
        .store_wb_o      (store_wb_o)
    );

    wb_master_arbiter u_wb_arbiter (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .ld_req_i (ld_wb_req),
        .st_req_i (st_wb_req),
        .ld_rsp_o (ld_wb_rsp),
        .st_rsp_o (st_wb_rsp),
        .wb_o     (wb_o),
        .wb_i     (wb_i)
    );

endmodule

/* logic/wb_master_arbiter.sv */
`timescale 1ns/10ps

module wb_master_arbiter (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  lsu_pkg::wb_req_t ld_req_i,
    input  lsu_pkg::wb_req_t st_req_i,
    output lsu_pkg::wb_rsp_t ld_rsp_o,
    output lsu_pkg::wb_rsp_t st_rsp_o,
    output lsu_pkg::wb_req_t wb_o,
    input  lsu_pkg::wb_rsp_t wb_i
);

    logic busy_q;
    logic owner_st_q;
    logic sel_st;
    logic done;

    // idle port goes to the store drain first
    assign sel_st = busy_q ? owner_st_q : st_req_i.cyc;
    assign done   = wb_i.ack || wb_i.err;

    assign wb_o = sel_st ? st_req_i : ld_req_i;

    // --------------------------------------------------
    // response routing
    // --------------------------------------------------
    always_comb begin
        ld_rsp_o.ack = wb_i.ack && !sel_st;
        ld_rsp_o.err = wb_i.err && !sel_st;
        ld_rsp_o.dat = wb_i.dat;
        st_rsp_o.ack = wb_i.ack && sel_st;
        st_rsp_o.err = wb_i.err && sel_st;
        st_rsp_o.dat = wb_i.dat;
    end

    // grant held until the slave ends the cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q     <= 1'b0;
            owner_st_q <= 1'b0;
        end else if (!busy_q) begin
            if (wb_o.cyc && !done) begin
                busy_q     <= 1'b1;
                owner_st_q <= sel_st;
            end
        end else if (done) begin
            busy_q <= 1'b0;
        end
    end

endmodule

/* logic/store_buffer.sv */
`timescale 1ns/10ps

module store_buffer #(
    parameter int unsigned STORE_BUF_DEPTH = 4
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                flush_i,
    input  logic                commit_i,
    input  lsu_pkg::lsu_ctrl_t  ctrl_i,
    input  lsu_pkg::data_t      ld_word_adr_i,
    output logic                hazard_o,
    output logic                pop_st_o,
    output logic                commit_ready_o,
    output logic                no_st_pending_o,
    output lsu_pkg::wb_req_t    wb_req_o,
    input  lsu_pkg::wb_rsp_t    wb_rsp_i,
    output lsu_pkg::wb_result_t store_wb_o
);

    localparam int unsigned PTR_W = $clog2(STORE_BUF_DEPTH);

    typedef struct packed {
        lsu_pkg::data_t adr;
        lsu_pkg::data_t dat;
        lsu_pkg::be_t   sel;
    } st_entry_t;

    st_entry_t [STORE_BUF_DEPTH-1:0] spec_mem_q;
    st_entry_t [STORE_BUF_DEPTH-1:0] com_mem_q;
    logic [STORE_BUF_DEPTH-1:0]      spec_vld_q;
    logic [STORE_BUF_DEPTH-1:0]      com_vld_q;
    logic [PTR_W-1:0]                spec_wr_q;
    logic [PTR_W-1:0]                spec_rd_q;
    logic [PTR_W-1:0]                com_wr_q;
    logic [PTR_W-1:0]                com_rd_q;
    logic                            st_req;
    logic                            take;
    logic                            push;
    logic                            drain_done;
    logic                            gap_q;
    st_entry_t                       new_entry;
    lsu_pkg::wb_result_t             wb_q;

    // --------------------------------------------------
    // intake from the request register
    // --------------------------------------------------
    // flushed stores are taken and dropped
    assign st_req   = ctrl_i.valid && !lsu_pkg::is_load(ctrl_i.op);
    assign take     = st_req && (flush_i || ctrl_i.misaligned || !spec_vld_q[spec_wr_q]);
    assign push     = take && !flush_i && !ctrl_i.misaligned;
    assign pop_st_o = take;

    // move store data onto its byte lanes
    assign new_entry.adr = {ctrl_i.vaddr[lsu_pkg::XLEN-1:2], 2'b00};
    assign new_entry.dat = ctrl_i.wdata << {ctrl_i.vaddr[1:0], 3'b000};
    assign new_entry.sel = ctrl_i.be;

    assign commit_ready_o  = !com_vld_q[com_wr_q];
    assign no_st_pending_o = ~|com_vld_q;

    // word match against every pending entry
    always_comb begin
        hazard_o = 1'b0;
        for (int i = 0; i < STORE_BUF_DEPTH; i++) begin
            if (spec_vld_q[i] && spec_mem_q[i].adr == ld_word_adr_i) begin
                hazard_o = 1'b1;
            end
            if (com_vld_q[i] && com_mem_q[i].adr == ld_word_adr_i) begin
                hazard_o = 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // drain of the oldest committed entry
    // --------------------------------------------------
    // one idle cycle after each ack so cyc drops between transfers
    assign drain_done = wb_rsp_i.ack || wb_rsp_i.err;

    always_comb begin
        wb_req_o.cyc = com_vld_q[com_rd_q] && !gap_q;
        wb_req_o.stb = com_vld_q[com_rd_q] && !gap_q;
        wb_req_o.we  = 1'b1;
        wb_req_o.adr = com_mem_q[com_rd_q].adr;
        wb_req_o.dat = com_mem_q[com_rd_q].dat;
        wb_req_o.sel = com_mem_q[com_rd_q].sel;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            spec_vld_q <= '0;
            com_vld_q  <= '0;
            spec_wr_q  <= '0;
            spec_rd_q  <= '0;
            com_wr_q   <= '0;
            com_rd_q   <= '0;
            gap_q      <= 1'b0;
            wb_q       <= '0;
        end else begin
            gap_q <= drain_done;
            if (push) begin
                spec_vld_q[spec_wr_q] <= 1'b1;
                spec_wr_q             <= spec_wr_q + 1'b1;
            end
            if (commit_i) begin
                spec_vld_q[spec_rd_q] <= 1'b0;
                spec_rd_q             <= spec_rd_q + 1'b1;
                com_vld_q[com_wr_q]   <= 1'b1;
                com_wr_q              <= com_wr_q + 1'b1;
            end
            if (flush_i) begin
                spec_vld_q <= '0;
                spec_wr_q  <= spec_rd_q + PTR_W'(commit_i);
            end
            if (drain_done) begin
                com_vld_q[com_rd_q] <= 1'b0;
                com_rd_q            <= com_rd_q + 1'b1;
            end
            // writeback one edge after the take
            wb_q.valid    <= take && !flush_i;
            wb_q.trans_id <= ctrl_i.trans_id;
            wb_q.result   <= ctrl_i.misaligned ? ctrl_i.vaddr : '0;
            wb_q.ex_valid <= ctrl_i.misaligned;
            wb_q.cause    <= lsu_pkg::ST_ADDR_MISALIGNED;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            spec_mem_q[spec_wr_q] <= new_entry;
        end
        if (commit_i) begin
            com_mem_q[com_wr_q] <= spec_mem_q[spec_rd_q];
        end
    end

    assign store_wb_o = wb_q;

endmodule

/* logic/load_unit.sv */
`timescale 1ns/10ps

module load_unit (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                flush_i,
    input  lsu_pkg::lsu_ctrl_t  ctrl_i,
    input  logic                hazard_i,
    output logic                pop_ld_o,
    output lsu_pkg::data_t      ld_word_adr_o,
    output lsu_pkg::wb_req_t    wb_req_o,
    input  lsu_pkg::wb_rsp_t    wb_rsp_i,
    output lsu_pkg::wb_result_t load_wb_o
);

    typedef enum logic [1:0] {IDLE, TRANSLATE, BUS} state_e;

    state_e              state_q;
    state_e              state_d;
    logic                ld_req;
    lsu_pkg::lsu_ctrl_t  ld_q;
    lsu_pkg::data_t      paddr_q;
    lsu_pkg::data_t      shifted;
    lsu_pkg::wb_result_t wb_d;
    lsu_pkg::wb_result_t wb_q;

    assign ld_req        = ctrl_i.valid && lsu_pkg::is_load(ctrl_i.op);
    assign ld_word_adr_o = {ctrl_i.vaddr[lsu_pkg::XLEN-1:2], 2'b00};
    assign shifted       = wb_rsp_i.dat >> {ld_q.vaddr[1:0], 3'b000};

    // --------------------------------------------------
    // control FSM
    // --------------------------------------------------
    always_comb begin
        state_d  = state_q;
        pop_ld_o = 1'b0;
        wb_d     = '0;
        case (state_q)
            IDLE: begin
                if (ld_req && flush_i) begin
                    pop_ld_o = 1'b1;
                end else if (ld_req && ctrl_i.misaligned) begin
                    pop_ld_o      = 1'b1;
                    wb_d.valid    = 1'b1;
                    wb_d.trans_id = ctrl_i.trans_id;
                    wb_d.result   = ctrl_i.vaddr;
                    wb_d.ex_valid = 1'b1;
                    wb_d.cause    = lsu_pkg::LD_ADDR_MISALIGNED;
                end else if (ld_req && !hazard_i) begin
                    pop_ld_o = 1'b1;
                    state_d  = TRANSLATE;
                end
            end
            // nothing has gone out yet so a flush still kills it
            TRANSLATE: state_d = flush_i ? IDLE : BUS;
            default: begin
                if (wb_rsp_i.ack || wb_rsp_i.err) begin
                    state_d       = IDLE;
                    wb_d.valid    = 1'b1;
                    wb_d.trans_id = ld_q.trans_id;
                    if (wb_rsp_i.err) begin
                        wb_d.result   = ld_q.vaddr;
                        wb_d.ex_valid = 1'b1;
                        wb_d.cause    = lsu_pkg::LD_ACCESS_FAULT;
                    end else begin
                        case (ld_q.op)
                            lsu_pkg::LB:  wb_d.result = {{24{shifted[7]}}, shifted[7:0]};
                            lsu_pkg::LBU: wb_d.result = {24'b0, shifted[7:0]};
                            lsu_pkg::LH:  wb_d.result = {{16{shifted[15]}}, shifted[15:0]};
                            lsu_pkg::LHU: wb_d.result = {16'b0, shifted[15:0]};
                            default:      wb_d.result = shifted;
                        endcase
                    end
                end
            end
        endcase
    end

    // address and sel held until ack or err
    always_comb begin
        wb_req_o.cyc = (state_q == BUS);
        wb_req_o.stb = (state_q == BUS);
        wb_req_o.we  = 1'b0;
        wb_req_o.adr = paddr_q;
        wb_req_o.dat = '0;
        wb_req_o.sel = ld_q.be;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            wb_q    <= '0;
        end else begin
            state_q <= state_d;
            wb_q    <= wb_d;
        end
    end

    // bare mode translation register
    always_ff @(posedge clk_i) begin
        if (pop_ld_o) begin
            ld_q <= ctrl_i;
        end
        paddr_q <= {ld_q.vaddr[lsu_pkg::XLEN-1:2], 2'b00};
    end

    assign load_wb_o = wb_q;

endmodule

/* logic/lsu_issue_ctrl.sv */
`timescale 1ns/10ps

module lsu_issue_ctrl (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               lsu_valid_i,
    input  lsu_pkg::lsu_req_t  lsu_req_i,
    input  logic               pop_ld_i,
    input  logic               pop_st_i,
    output logic               lsu_ready_o,
    output lsu_pkg::lsu_ctrl_t ctrl_o
);

    lsu_pkg::data_t     vaddr;
    lsu_pkg::be_t       be;
    logic [1:0]         size;
    logic               misaligned;
    logic               ready;
    lsu_pkg::lsu_ctrl_t req_q;

    // --------------------------------------------------
    // address generation
    // --------------------------------------------------
    assign vaddr = lsu_req_i.operand_a + lsu_req_i.imm;
    assign size  = lsu_pkg::op_size(lsu_req_i.op);
    assign be    = lsu_pkg::be_gen(vaddr[1:0], size);

    // bytes never misalign
    always_comb begin
        case (size)
            2'd1:    misaligned = vaddr[0];
            2'd2:    misaligned = |vaddr[1:0];
            default: misaligned = 1'b0;
        endcase
    end

    // --------------------------------------------------
    // request register
    // --------------------------------------------------
    // a pop frees the slot in the same cycle so a new request can follow
    assign ready       = !req_q.valid || pop_ld_i || pop_st_i;
    assign lsu_ready_o = ready;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_q <= '0;
        end else if (lsu_valid_i && ready) begin
            req_q.valid      <= 1'b1;
            req_q.vaddr      <= vaddr;
            req_q.wdata      <= lsu_req_i.operand_b;
            req_q.be         <= be;
            req_q.op         <= lsu_req_i.op;
            req_q.trans_id   <= lsu_req_i.trans_id;
            req_q.misaligned <= misaligned;
        end else if (pop_ld_i || pop_st_i) begin
            req_q.valid <= 1'b0;
        end
    end

    assign ctrl_o = req_q;

endmodule

/* logic/lsu_pkg.sv */
package lsu_pkg;

    localparam int unsigned XLEN          = 32;
    localparam int unsigned TRANS_ID_BITS = 3;

    typedef logic [XLEN-1:0]          data_t;
    typedef logic [XLEN/8-1:0]        be_t;
    typedef logic [TRANS_ID_BITS-1:0] trans_id_t;

    typedef enum logic [3:0] {
        LB, LBU, LH, LHU, LW, SB, SH, SW
    } lsu_op_e;

    typedef enum logic [3:0] {
        LD_ADDR_MISALIGNED = 4'd4,
        LD_ACCESS_FAULT    = 4'd5,
        ST_ADDR_MISALIGNED = 4'd6,
        ST_ACCESS_FAULT    = 4'd7
    } exc_cause_e;

    // request as it leaves the issue stage
    typedef struct packed {
        lsu_op_e   op;
        data_t     operand_a;
        data_t     imm;
        data_t     operand_b;
        trans_id_t trans_id;
    } lsu_req_t;

    typedef struct packed {
        logic      valid;
        data_t     vaddr;
        data_t     wdata;
        be_t       be;
        lsu_op_e   op;
        trans_id_t trans_id;
        logic      misaligned;
    } lsu_ctrl_t;

    // result carries the faulting address when ex_valid is set
    typedef struct packed {
        logic       valid;
        trans_id_t  trans_id;
        data_t      result;
        logic       ex_valid;
        exc_cause_e cause;
    } wb_result_t;

    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        data_t adr;
        data_t dat;
        be_t   sel;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        logic  err;
        data_t dat;
    } wb_rsp_t;

    function automatic logic is_load(input lsu_op_e op);
        return op inside {LB, LBU, LH, LHU, LW};
    endfunction

    // 0 byte, 1 half word, 2 word
    function automatic logic [1:0] op_size(input lsu_op_e op);
        case (op)
            LB, LBU, SB: return 2'd0;
            LH, LHU, SH: return 2'd1;
            default:     return 2'd2;
        endcase
    endfunction

    function automatic be_t be_gen(input logic [1:0] addr, input logic [1:0] size);
        case (size)
            2'd0:    return be_t'(4'b0001 << addr);
            2'd1:    return be_t'(4'b0011 << addr);
            default: return 4'b1111;
        endcase
    endfunction

endpackage
